// File: src/pcis_pkg.sv
/* PCIe slave host master
   shared definitions */

package pcis_pkg;

   // ------------------------------
   // Bus geometry
   // ------------------------------
   localparam int LINE_BYTES = 64;
   localparam int WORD_BYTES = 4;

   // Address and ID of one transaction
   typedef logic [63:0] addr_t;
   typedef logic [4:0]  axi_id_t;
   typedef logic [7:0]  len_t;

   // Peek and poke word
   typedef logic [WORD_BYTES*8-1:0] word_t;

   // One data beat and its byte strobes
   typedef logic [LINE_BYTES*8-1:0] line_t;
   typedef logic [LINE_BYTES-1:0]   strb_t;

   // Byte offset of a word inside a beat
   typedef logic [$clog2(LINE_BYTES)-1:0] lane_t;

   // AXI response code
   typedef logic [1:0] resp_t;

   localparam resp_t RESP_OKAY = 2'b00;

   // ------------------------------
   // Lane helpers
   // ------------------------------
   // Strobes of one word before it is shifted to its lane
   localparam logic [WORD_BYTES-1:0] WORD_STRB = '1;

   // AW and AR queue entries carry {id, addr}
   localparam int CMD_BITS = $bits(axi_id_t) + $bits(addr_t);

   // W queue entries carry {strb, data}
   localparam int W_BITS = $bits(strb_t) + $bits(line_t);

endpackage

// File: src/sync_fifo.sv
/* Synchronous FIFO */

`timescale 1ns/100ps

module sync_fifo #(
   parameter int DEPTH = 4,
   parameter int WIDTH = 8,
   localparam int CNT_W = $clog2(DEPTH + 1),
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
   input  logic             clk_out,
   input  logic             reset_i,
   input  logic             push_i,
   input  logic [WIDTH-1:0] push_data_i,
   input  logic             pop_i,
   output logic [WIDTH-1:0] pop_data_o,
   output logic             empty_o,
   output logic             full_o,
   output logic [CNT_W-1:0] count_o
);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   // Pointer wrap for depths that are not a power of two
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   // Storage
   always_ff @(posedge clk_out) begin
      if (push_i) begin
         mem[wr_ptr] <= push_data_i;
      end
   end

   // Pointers and occupancy
   always_ff @(posedge clk_out) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop_i) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({push_i, pop_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Head is visible without a pop
   assign pop_data_o = mem[rd_ptr];
   assign empty_o    = (count == '0);
   assign full_o     = (count == CNT_W'(DEPTH));
   assign count_o    = count;

   a_no_overflow: assert property (@(posedge clk_out) disable iff (reset_i)
      push_i |-> !full_o);

   a_no_underflow: assert property (@(posedge clk_out) disable iff (reset_i)
      pop_i |-> !empty_o);

endmodule

// File: src/send_queue.sv
/* AXI command queue */

`timescale 1ns/100ps

module send_queue #(
   parameter int DEPTH = 4,
   parameter int WIDTH = 8
) (
   input  logic             clk_out,
   input  logic             reset_i,
   input  logic             push_i,
   input  logic [WIDTH-1:0] push_data_i,
   output logic             full_o,
   output logic             valid_o,
   output logic [WIDTH-1:0] payload_o,
   input  logic             ready_i
);

   logic             head_empty;
   logic [WIDTH-1:0] head_data;
   logic             load;
   logic             valid_q;
   logic [WIDTH-1:0] payload_q;

   // Refill the output stage when it is idle or transfers this cycle
   assign load = !head_empty && (!valid_q || ready_i);

   sync_fifo #(
      .DEPTH (DEPTH),
      .WIDTH (WIDTH)
   ) u_fifo (
      .clk_out     (clk_out),
      .reset_i     (reset_i),
      .push_i      (push_i),
      .push_data_i (push_data_i),
      .pop_i       (load),
      .pop_data_o  (head_data),
      .empty_o     (head_empty),
      .full_o      (full_o),
      .count_o     ()
   );

   // ------------------------------
   // Output stage
   // ------------------------------
   always_ff @(posedge clk_out) begin
      if (reset_i) begin
         valid_q <= 1'b0;
      end else if (load) begin
         valid_q <= 1'b1;
      end else if (ready_i) begin
         valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_out) begin
      if (load) begin
         payload_q <= head_data;
      end
   end

   assign valid_o   = valid_q;
   assign payload_o = payload_q;

   // Beat held stable under back-pressure
   a_hold_beat: assert property (@(posedge clk_out) disable iff (reset_i)
      valid_o && !ready_i |=> valid_o && $stable(payload_o));

endmodule

// File: src/request_splitter.sv
/* Peek and poke request splitter */

`timescale 1ns/100ps

module request_splitter
   import pcis_pkg::*;
(
   // Requester strobe
   input  logic                req_valid_i,
   input  logic                req_write_i,
   input  addr_t               req_addr_i,
   input  word_t               req_wdata_i,
   input  axi_id_t             req_id_i,
   output logic                req_full_o,

   // Write address queue
   output logic                aw_push_o,
   output logic [CMD_BITS-1:0] aw_entry_o,
   input  logic                aw_full_i,

   // Write data queue
   output logic                w_push_o,
   output line_t               w_data_o,
   output strb_t               w_strb_o,
   input  logic                w_full_i,

   // Read address queue
   output logic                ar_push_o,
   output logic [CMD_BITS-1:0] ar_entry_o,
   input  logic                ar_full_i,

   // Lane bookkeeping in the collector
   output logic                rd_push_o,
   output lane_t               rd_lane_o,
   input  logic                lane_full_i
);

   logic  accept;
   logic  is_poke;
   logic  is_peek;
   lane_t lane;

   // Byte offset of the word within the beat
   assign lane = req_addr_i[$bits(lane_t)-1:0];

   // Any full target stalls the requester
   assign req_full_o = aw_full_i | w_full_i | ar_full_i | lane_full_i;

   // Strobes seen while full are dropped
   assign accept  = req_valid_i && !req_full_o;
   assign is_poke = accept && req_write_i;
   assign is_peek = accept && !req_write_i;

   // ------------------------------
   // Poke path
   // ------------------------------
   assign aw_push_o  = is_poke;
   assign aw_entry_o = {req_id_i, req_addr_i};

   assign w_push_o = is_poke;
   // Word and strobes shifted up to the addressed byte lane
   assign w_data_o = line_t'(req_wdata_i) << {lane, 3'b000};
   assign w_strb_o = strb_t'(WORD_STRB) << lane;

   // ------------------------------
   // Peek path
   // ------------------------------
   assign ar_push_o  = is_peek;
   assign ar_entry_o = {req_id_i, req_addr_i};

   // Lane is remembered so the returned line can be reduced later
   assign rd_push_o = is_peek;
   assign rd_lane_o = lane;

endmodule

// File: src/response_collector.sv
/* B and R response collector */

`timescale 1ns/100ps

module response_collector
   import pcis_pkg::*;
#(
   parameter int RD_DEPTH = 16
) (
   input  logic    clk_out,
   input  logic    reset_i,
   // Write response channel
   input  axi_id_t bid_i,
   input  resp_t   bresp_i,
   input  logic    bvalid_i,
   output logic    bready_o,
   // Read data channel
   input  axi_id_t rid_i,
   input  line_t   rdata_i,
   input  resp_t   rresp_i,
   input  logic    rvalid_i,
   output logic    rready_o,
   // Lanes of issued peeks
   input  logic    rd_push_i,
   input  lane_t   rd_lane_i,
   output logic    lane_full_o,
   // Ordered results
   output logic    rsp_valid_o,
   output logic    rsp_write_o,
   output axi_id_t rsp_id_o,
   output resp_t   rsp_resp_o,
   output word_t   rsp_rdata_o,
   input  logic    rsp_pop_i
);

   // Order store keeps one record per capture cycle
   localparam int ORD_DEPTH = 4 * RD_DEPTH;
   localparam int ORD_LIMIT = 3 * RD_DEPTH;
   localparam int ORD_W     = 2 + $bits(axi_id_t) + $bits(resp_t);
   localparam int RET_W     = $bits(axi_id_t) + $bits(resp_t) + $bits(word_t);
   localparam int RD_CNT_W  = $clog2(RD_DEPTH + 1);
   localparam int ORD_CNT_W = $clog2(ORD_DEPTH + 1);

   logic                 bready_q;
   logic                 rready_q;
   logic                 b_accept;
   logic                 r_accept;
   logic                 lane_empty;
   logic                 lane_full;
   lane_t                lane_head;
   word_t                r_word;
   logic [RET_W-1:0]     ret_head;
   logic [RD_CNT_W-1:0]  ret_count;
   logic [RD_CNT_W:0]    ret_next;
   logic                 ret_pop;
   logic [ORD_W-1:0]     ord_head;
   logic [ORD_CNT_W-1:0] ord_count;
   logic                 ord_empty;
   logic                 ord_pop;
   logic                 head_b;
   logic                 head_r;
   axi_id_t              head_bid;
   resp_t                head_bresp;
   axi_id_t              ret_id;
   resp_t                ret_resp;
   word_t                ret_word;
   logic                 b_done;
   logic                 show_b;
   logic                 take;

   assign b_accept = bvalid_i && bready_q;
   assign r_accept = rvalid_i && rready_q;

   // ------------------------------
   // Capture
   // ------------------------------
   sync_fifo #(.DEPTH(RD_DEPTH), .WIDTH($bits(lane_t))) u_lane_fifo (
      .clk_out     (clk_out),
      .reset_i     (reset_i),
      .push_i      (rd_push_i),
      .push_data_i (rd_lane_i),
      .pop_i       (r_accept),
      .pop_data_o  (lane_head),
      .empty_o     (lane_empty),
      .full_o      (lane_full),
      .count_o     ()
   );

   // Oldest peek lane selects the word of this beat
   assign r_word = word_t'(rdata_i >> {lane_head, 3'b000});

   sync_fifo #(.DEPTH(RD_DEPTH), .WIDTH(RET_W)) u_ret_fifo (
      .clk_out     (clk_out),
      .reset_i     (reset_i),
      .push_i      (r_accept),
      .push_data_i ({rid_i, rresp_i, r_word}),
      .pop_i       (ret_pop),
      .pop_data_o  (ret_head),
      .empty_o     (),
      .full_o      (),
      .count_o     (ret_count)
   );

   sync_fifo #(.DEPTH(ORD_DEPTH), .WIDTH(ORD_W)) u_ord_fifo (
      .clk_out     (clk_out),
      .reset_i     (reset_i),
      .push_i      (b_accept || r_accept),
      .push_data_i ({b_accept, r_accept, bid_i, bresp_i}),
      .pop_i       (ord_pop),
      .pop_data_o  (ord_head),
      .empty_o     (ord_empty),
      .full_o      (),
      .count_o     (ord_count)
   );

   // Fill of the R store after this edge
   assign ret_next = {1'b0, ret_count} + r_accept - ret_pop;

   always_ff @(posedge clk_out) begin
      if (reset_i) begin
         bready_q <= 1'b0;
         rready_q <= 1'b0;
      end else begin
         bready_q <= 1'b1;
         rready_q <= (ret_next < RD_DEPTH);
      end
   end

   assign bready_o = bready_q;
   assign rready_o = rready_q;

   // Stop new requests before the order store runs short of room for B
   assign lane_full_o = lane_full || (ord_count >= ORD_LIMIT);

   // ------------------------------
   // Result output
   // ------------------------------
   assign {head_b, head_r, head_bid, head_bresp} = ord_head;
   assign {ret_id, ret_resp, ret_word} = ret_head;

   // A record with both kinds shows its B first
   assign show_b = head_b && !b_done;
   assign take   = rsp_pop_i && rsp_valid_o;

   assign ord_pop = take && !(show_b && head_r);
   assign ret_pop = take && !show_b;

   always_ff @(posedge clk_out) begin
      if (reset_i) begin
         b_done <= 1'b0;
      end else if (take) begin
         b_done <= show_b && head_r;
      end
   end

   assign rsp_valid_o = !ord_empty;
   assign rsp_write_o = show_b;
   assign rsp_id_o    = show_b ? head_bid : ret_id;
   assign rsp_resp_o  = show_b ? head_bresp : ret_resp;
   assign rsp_rdata_o = show_b ? '0 : ret_word;

   // Every R beat belongs to a peek issued by the splitter
   a_lane_known: assert property (@(posedge clk_out) disable iff (reset_i)
      rvalid_i && rready_o |-> !lane_empty);

endmodule

// File: src/pcis_host_top.sv
/* PCIe slave host AXI master */

`timescale 1ns/100ps

module pcis_host_top
   import pcis_pkg::*;
#(
   parameter int CMD_DEPTH = 4,
   parameter int RD_DEPTH  = 16
) (
   input  logic    clk_out,
   input  logic    reset_i,
   // Requester
   input  logic    req_valid_i,
   input  logic    req_write_i,
   input  addr_t   req_addr_i,
   input  word_t   req_wdata_i,
   input  axi_id_t req_id_i,
   output logic    req_full_o,
   output logic    rsp_valid_o,
   output logic    rsp_write_o,
   output axi_id_t rsp_id_o,
   output resp_t   rsp_resp_o,
   output word_t   rsp_rdata_o,
   input  logic    rsp_pop_i,
   // AXI write address
   output addr_t   awaddr_o,
   output axi_id_t awid_o,
   output len_t    awlen_o,
   output logic    awvalid_o,
   input  logic    awready_i,
   // AXI write data
   output line_t   wdata_o,
   output strb_t   wstrb_o,
   output logic    wlast_o,
   output logic    wvalid_o,
   input  logic    wready_i,
   // AXI write response
   input  axi_id_t bid_i,
   input  resp_t   bresp_i,
   input  logic    bvalid_i,
   output logic    bready_o,
   // AXI read address
   output addr_t   araddr_o,
   output axi_id_t arid_o,
   output len_t    arlen_o,
   output logic    arvalid_o,
   input  logic    arready_i,
   // AXI read data
   input  axi_id_t rid_i,
   input  line_t   rdata_i,
   input  resp_t   rresp_i,
   input  logic    rlast_i,
   input  logic    rvalid_i,
   output logic    rready_o
);

   logic                aw_push;
   logic                aw_full;
   logic [CMD_BITS-1:0] aw_entry;
   logic [CMD_BITS-1:0] aw_payload;
   logic                w_push;
   logic                w_full;
   line_t               w_data;
   strb_t               w_strb;
   logic [W_BITS-1:0]   w_payload;
   logic                ar_push;
   logic                ar_full;
   logic [CMD_BITS-1:0] ar_entry;
   logic [CMD_BITS-1:0] ar_payload;
   logic                rd_push;
   lane_t               rd_lane;
   logic                lane_full;

   request_splitter u_splitter (
      .req_valid_i (req_valid_i),
      .req_write_i (req_write_i),
      .req_addr_i  (req_addr_i),
      .req_wdata_i (req_wdata_i),
      .req_id_i    (req_id_i),
      .req_full_o  (req_full_o),
      .aw_push_o   (aw_push),
      .aw_entry_o  (aw_entry),
      .aw_full_i   (aw_full),
      .w_push_o    (w_push),
      .w_data_o    (w_data),
      .w_strb_o    (w_strb),
      .w_full_i    (w_full),
      .ar_push_o   (ar_push),
      .ar_entry_o  (ar_entry),
      .ar_full_i   (ar_full),
      .rd_push_o   (rd_push),
      .rd_lane_o   (rd_lane),
      .lane_full_i (lane_full)
   );

   // ------------------------------
   // Outgoing channels
   // ------------------------------
   send_queue #(.DEPTH(CMD_DEPTH), .WIDTH(CMD_BITS)) u_aw_queue (
      .clk_out     (clk_out),
      .reset_i     (reset_i),
      .push_i      (aw_push),
      .push_data_i (aw_entry),
      .full_o      (aw_full),
      .valid_o     (awvalid_o),
      .payload_o   (aw_payload),
      .ready_i     (awready_i)
   );

   send_queue #(.DEPTH(CMD_DEPTH), .WIDTH(W_BITS)) u_w_queue (
      .clk_out     (clk_out),
      .reset_i     (reset_i),
      .push_i      (w_push),
      .push_data_i ({w_strb, w_data}),
      .full_o      (w_full),
      .valid_o     (wvalid_o),
      .payload_o   (w_payload),
      .ready_i     (wready_i)
   );

   send_queue #(.DEPTH(CMD_DEPTH), .WIDTH(CMD_BITS)) u_ar_queue (
      .clk_out     (clk_out),
      .reset_i     (reset_i),
      .push_i      (ar_push),
      .push_data_i (ar_entry),
      .full_o      (ar_full),
      .valid_o     (arvalid_o),
      .payload_o   (ar_payload),
      .ready_i     (arready_i)
   );

   assign {awid_o, awaddr_o} = aw_payload;
   assign {wstrb_o, wdata_o} = w_payload;
   assign {arid_o, araddr_o} = ar_payload;

   // Single beat transfers only
   assign awlen_o = '0;
   assign arlen_o = '0;
   assign wlast_o = 1'b1;

   response_collector #(.RD_DEPTH(RD_DEPTH)) u_collector (
      .clk_out     (clk_out),
      .reset_i     (reset_i),
      .bid_i       (bid_i),
      .bresp_i     (bresp_i),
      .bvalid_i    (bvalid_i),
      .bready_o    (bready_o),
      .rid_i       (rid_i),
      .rdata_i     (rdata_i),
      .rresp_i     (rresp_i),
      .rvalid_i    (rvalid_i),
      .rready_o    (rready_o),
      .rd_push_i   (rd_push),
      .rd_lane_i   (rd_lane),
      .lane_full_o (lane_full),
      .rsp_valid_o (rsp_valid_o),
      .rsp_write_o (rsp_write_o),
      .rsp_id_o    (rsp_id_o),
      .rsp_resp_o  (rsp_resp_o),
      .rsp_rdata_o (rsp_rdata_o),
      .rsp_pop_i   (rsp_pop_i)
   );

   // Requester honours the full level
   a_req_not_full: assert property (@(posedge clk_out) disable iff (reset_i)
      req_valid_i |-> !req_full_o);

   // Slave returns single beat reads
   a_r_single: assert property (@(posedge clk_out) disable iff (reset_i)
      rvalid_i |-> rlast_i);

endmodule

// File: bench/axi_slave_model.sv
/* Behavioral AXI slave */

`timescale 1ns/100ps

module axi_slave_model
   import pcis_pkg::*;
(
   input  logic    clk_out,
   input  logic    reset_i,
   input  addr_t   awaddr_i,
   input  axi_id_t awid_i,
   input  logic    awvalid_i,
   output logic    awready_o,
   input  line_t   wdata_i,
   input  strb_t   wstrb_i,
   input  logic    wvalid_i,
   output logic    wready_o,
   output axi_id_t bid_o,
   output resp_t   bresp_o,
   output logic    bvalid_o,
   input  logic    bready_i,
   input  addr_t   araddr_i,
   input  axi_id_t arid_i,
   input  logic    arvalid_i,
   output logic    arready_o,
   output axi_id_t rid_o,
   output line_t   rdata_o,
   output resp_t   rresp_o,
   output logic    rlast_o,
   output logic    rvalid_o,
   input  logic    rready_i,
   output int      strb_err_o,
   output int      r_count_o
);

   // Word memory keyed by word aligned byte address
   word_t mem [addr_t];

   logic [CMD_BITS-1:0] aw_q [$];
   logic [W_BITS-1:0]   w_q [$];
   axi_id_t             b_q [$];
   logic [$bits(axi_id_t)+$bits(line_t)-1:0] r_q [$];

   // DUT side as seen during the cycle before an edge
   logic                aw_s, w_s, ar_s, b_s, r_s;
   logic [CMD_BITS-1:0] aw_hold;
   logic [CMD_BITS-1:0] ar_hold;
   logic [W_BITS-1:0]   w_hold;

   function automatic line_t read_line(input addr_t addr);
      line_t line;
      addr_t key;
      line = '0;
      for (int k = 0; k < LINE_BYTES / WORD_BYTES; k++) begin
         key = {addr[63:6], 6'b0} + addr_t'(k * WORD_BYTES);
         if (mem.exists(key)) begin
            line[k*32 +: 32] = mem[key];
         end
      end
      return line;
   endfunction

   function automatic void write_line(input addr_t addr, input line_t data, input strb_t strb);
      addr_t key;
      word_t word;
      for (int b = 0; b < LINE_BYTES; b++) begin
         if (strb[b]) begin
            key  = {addr[63:6], 6'b0} + addr_t'(b & ~3);
            word = mem.exists(key) ? mem[key] : '0;
            word[(b % 4)*8 +: 8] = data[b*8 +: 8];
            mem[key] = word;
         end
      end
   endfunction

   initial begin
      {awready_o, wready_o, arready_o, bvalid_o, rvalid_o} = '0;
      {aw_s, w_s, ar_s, b_s, r_s} = '0;
      bid_o      = '0;
      bresp_o    = RESP_OKAY;
      rid_o      = '0;
      rdata_o    = '0;
      rresp_o    = RESP_OKAY;
      rlast_o    = 1'b1;
      strb_err_o = 0;
      r_count_o  = 0;
   end

   always @(posedge clk_out) begin : serve
      logic    in_reset;
      axi_id_t id;
      addr_t   addr;
      line_t   data;
      strb_t   strb;
      strb_t   exp_strb;
      in_reset = reset_i;
      #1;
      if (in_reset) begin
         {awready_o, wready_o, arready_o, bvalid_o, rvalid_o} = '0;
         {aw_s, w_s, ar_s, b_s, r_s} = '0;
      end else begin
         // Beats that moved on the edge just passed
         if (aw_s && awready_o) begin
            aw_q.push_back(aw_hold);
         end
         if (w_s && wready_o) begin
            w_q.push_back(w_hold);
         end
         if (ar_s && arready_o) begin
            {id, addr} = ar_hold;
            r_q.push_back({id, read_line(addr)});
         end
         if (bvalid_o && b_s) begin
            bvalid_o = 1'b0;
         end
         if (rvalid_o && r_s) begin
            rvalid_o = 1'b0;
            r_count_o++;
         end

         // Write address paired with its data beat in order
         while (aw_q.size() > 0 && w_q.size() > 0) begin
            {id, addr} = aw_q.pop_front();
            {strb, data} = w_q.pop_front();
            exp_strb = '0;
            for (int b = 0; b < LINE_BYTES; b++) begin
               // Four bytes starting at the addressed lane
               exp_strb[b] = (b >= int'(addr[5:0])) && (b < int'(addr[5:0]) + WORD_BYTES);
            end
            assert (strb == exp_strb && $countones(strb) == WORD_BYTES) else begin
               $display("Error %0t: W beat for address %h has strobes %h, expected %h",
                        $time, addr, strb, exp_strb);
               strb_err_o++;
            end
            write_line(addr, data, strb);
            b_q.push_back(id);
         end

         // Responses go out after a random delay
         if (!bvalid_o && b_q.size() > 0 && $urandom_range(1, 0) == 1) begin
            bid_o    = b_q.pop_front();
            bresp_o  = RESP_OKAY;
            bvalid_o = 1'b1;
         end
         if (!rvalid_o && r_q.size() > 0 && $urandom_range(1, 0) == 1) begin
            {rid_o, rdata_o} = r_q.pop_front();
            rresp_o  = RESP_OKAY;
            rlast_o  = 1'b1;
            rvalid_o = 1'b1;
         end

         awready_o = ($urandom_range(3, 0) != 0);
         wready_o  = ($urandom_range(3, 0) != 0);
         arready_o = ($urandom_range(3, 0) != 0);

         aw_s    = awvalid_i;
         aw_hold = {awid_i, awaddr_i};
         w_s     = wvalid_i;
         w_hold  = {wstrb_i, wdata_i};
         ar_s    = arvalid_i;
         ar_hold = {arid_i, araddr_i};
         b_s     = bready_i;
         r_s     = rready_i;
      end
   end

endmodule

// File: bench/tb_pcis_host.sv
/* PCIe slave host master testbench */

`timescale 1ns/100ps

module tb_pcis_host
   import pcis_pkg::*;
();

   localparam int    CMD_DEPTH    = 4;
   localparam int    RD_DEPTH     = 16;
   localparam int    CLK_PERIOD   = 8;
   localparam int    RESET_CYCLES = 16;
   localparam int    N_PAIRS      = 10;
   localparam int    N_RANDOM     = 300;
   localparam int    N_BACKLOG    = 20;
   localparam int    N_LANES      = LINE_BYTES / WORD_BYTES;
   localparam int    N_REQ        = 2 * N_PAIRS + N_RANDOM + N_BACKLOG + N_LANES;
   localparam int    WATCHDOG_NS  = N_REQ * 200 + RESET_CYCLES * CLK_PERIOD;
   localparam int    ADDR_LINES   = 8;
   localparam addr_t ADDR_BASE    = 64'h0000_00a0_0000_0000;
   localparam int    EXP_W        = 1 + $bits(axi_id_t) + $bits(word_t);

   logic    clk_out = 1'b0;
   logic    reset_i;
   logic    req_valid_i, req_write_i, req_full_o;
   addr_t   req_addr_i;
   word_t   req_wdata_i;
   axi_id_t req_id_i;
   logic    rsp_valid_o, rsp_write_o, rsp_pop_i;
   axi_id_t rsp_id_o;
   resp_t   rsp_resp_o;
   word_t   rsp_rdata_o;
   addr_t   awaddr_o, araddr_o;
   axi_id_t awid_o, arid_o, bid_i, rid_i;
   len_t    awlen_o, arlen_o;
   logic    awvalid_o, awready_i, wlast_o, wvalid_o, wready_i;
   logic    bvalid_i, bready_o, arvalid_o, arready_i;
   logic    rlast_i, rvalid_i, rready_o;
   line_t   wdata_o, rdata_i;
   strb_t   wstrb_o;
   resp_t   bresp_i, rresp_i;
   int      strb_err;
   int      r_count;

   // Requester model
   word_t            model_mem [addr_t];
   logic [EXP_W-1:0] exp_q [$];
   axi_id_t          next_id = '0;
   logic             last_write = 1'b0;
   logic             pop_en = 1'b1;
   int               issued_cnt = 0;
   int               popped_cnt = 0;
   int               pokes_issued = 0;
   int               pokes_seen = 0;
   int               checks = 0;
   int               errors = 0;

   always #(CLK_PERIOD / 2) clk_out = ~clk_out;

   pcis_host_top #(.CMD_DEPTH(CMD_DEPTH), .RD_DEPTH(RD_DEPTH)) DUT (.*);

   axi_slave_model u_slave (
      .clk_out    (clk_out),
      .reset_i    (reset_i),
      .awaddr_i   (awaddr_o),
      .awid_i     (awid_o),
      .awvalid_i  (awvalid_o),
      .awready_o  (awready_i),
      .wdata_i    (wdata_o),
      .wstrb_i    (wstrb_o),
      .wvalid_i   (wvalid_o),
      .wready_o   (wready_i),
      .bid_o      (bid_i),
      .bresp_o    (bresp_i),
      .bvalid_o   (bvalid_i),
      .bready_i   (bready_o),
      .araddr_i   (araddr_o),
      .arid_i     (arid_o),
      .arvalid_i  (arvalid_o),
      .arready_o  (arready_i),
      .rid_o      (rid_i),
      .rdata_o    (rdata_i),
      .rresp_o    (rresp_i),
      .rlast_o    (rlast_i),
      .rvalid_o   (rvalid_i),
      .rready_i   (rready_o),
      .strb_err_o (strb_err),
      .r_count_o  (r_count)
   );

   // Single beat attributes on every presented command and data beat
   always @(negedge clk_out) begin
      if (!reset_i) begin
         assert ((!awvalid_o || awlen_o == '0) && (!arvalid_o || arlen_o == '0)
                 && (!wvalid_o || wlast_o)) else begin
            $display("Error %0t: awlen %0d, arlen %0d, wlast %0b on a valid beat",
                     $time, awlen_o, arlen_o, wlast_o);
            errors++;
         end
      end
   end

   // One clock, landing just after the rising edge
   task automatic step();
      @(posedge clk_out);
      #1;
   endtask

   task automatic drain();
      while (popped_cnt != issued_cnt) begin
         step();
      end
   endtask

   function automatic addr_t random_addr();
      return ADDR_BASE + addr_t'($urandom_range(ADDR_LINES - 1, 0) * LINE_BYTES)
                       + addr_t'($urandom_range(N_LANES - 1, 0) * WORD_BYTES);
   endfunction

   function automatic word_t model_word(input addr_t addr);
      return model_mem.exists(addr) ? model_mem[addr] : '0;
   endfunction

   task automatic issue(input logic write, input addr_t addr, input word_t data);
      // Other kind drained first so the slave sees pokes and peeks in order
      if (write != last_write) begin
         drain();
      end
      while (req_full_o) begin
         step();
      end
      req_valid_i = 1'b1;
      req_write_i = write;
      req_addr_i  = addr;
      req_wdata_i = data;
      req_id_i    = next_id;
      if (write) begin
         model_mem[addr] = data;
         pokes_issued++;
      end
      exp_q.push_back({write, next_id, write ? word_t'(0) : model_word(addr)});
      next_id++;
      issued_cnt++;
      last_write = write;
      step();
      req_valid_i = 1'b0;
   endtask

   task automatic check_result();
      logic    exp_write;
      axi_id_t exp_id;
      word_t   exp_data;
      checks++;
      assert (exp_q.size() > 0) else begin
         $display("A result appeared at %0t ns with no request waiting for it", $time);
         errors++;
         return;
      end
      {exp_write, exp_id, exp_data} = exp_q.pop_front();
      assert (rsp_write_o == exp_write && rsp_id_o == exp_id) else begin
         $display("Error %0t: result write %0b id %0d, expected write %0b id %0d",
                  $time, rsp_write_o, rsp_id_o, exp_write, exp_id);
         errors++;
      end
      assert (rsp_resp_o == RESP_OKAY) else begin
         $display("Error %0t: response %0d for id %0d", $time, rsp_resp_o, rsp_id_o);
         errors++;
      end
      if (!exp_write) begin
         assert (rsp_rdata_o == exp_data) else begin
            $display("Error %0t: peek id %0d read %h, expected %h",
                     $time, exp_id, rsp_rdata_o, exp_data);
            errors++;
         end
      end
      // Write results the DUT reports as completed
      if (rsp_write_o && rsp_resp_o == RESP_OKAY) begin
         pokes_seen++;
      end
   endtask

   task automatic check_idle(input string when);
      assert (!awvalid_o && !wvalid_o && !arvalid_o && !bready_o && !rready_o && !rsp_valid_o)
      else begin
         $display("Error %0t: AXI valid, ready or rsp_valid high %s", $time, when);
         errors++;
      end
   endtask

   task automatic report_test(input int num, input string name, input int err_before);
      $display("Test %0d %s: %s, %0d errors", num, name,
               (errors == err_before) ? "passed" : "FAILED", errors - err_before);
   endtask

   // Result consumer
   initial begin : pop_results
      rsp_pop_i = 1'b0;
      forever begin
         step();
         rsp_pop_i = 1'b0;
         if (pop_en && rsp_valid_o) begin
            check_result();
            rsp_pop_i = 1'b1;
            popped_cnt++;
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the DUT stopped answering", WATCHDOG_NS);
      $display("Simulation failed");
      $finish;
   end

   initial begin : main
      int    seed_val;
      int    err0;
      int    r_base;
      int    wait_cycles;
      addr_t addr;
      word_t data;
      seed_val    = $urandom(32'hc943);
      reset_i     = 1'b1;
      req_valid_i = 1'b0;
      req_write_i = 1'b0;
      req_addr_i  = '0;
      req_wdata_i = '0;
      req_id_i    = '0;

      // ------------------------------
      // Reset
      // ------------------------------
      err0 = errors;
      repeat (RESET_CYCLES) begin
         step();
         check_idle("during reset");
      end
      reset_i = 1'b0;
      check_idle("right after reset");
      step();
      assert (bready_o) else begin
         $display("Error %0t: bready_o still low after reset", $time);
         errors++;
      end
      report_test(1, "reset state", err0);

      // Poke then peek of the same word
      err0 = errors;
      for (int i = 0; i < N_PAIRS; i++) begin
         addr = random_addr();
         data = $urandom();
         issue(1'b1, addr, data);
         issue(1'b0, addr, '0);
      end
      drain();
      report_test(2, "poke then peek", err0);

      // ------------------------------
      // Random mix
      // ------------------------------
      err0 = errors;
      for (int i = 0; i < N_RANDOM; i++) begin
         issue(logic'($urandom_range(1, 0)), random_addr(), $urandom());
      end
      drain();
      report_test(3, "random mix", err0);

      // Backlog of peeks with nobody popping
      err0 = errors;
      pop_en = 1'b0;
      r_base = r_count;
      for (int i = 0; i < N_BACKLOG; i++) begin
         issue(1'b0, random_addr(), '0);
      end
      wait_cycles = 0;
      while (rready_o && wait_cycles < 500) begin
         step();
         wait_cycles++;
      end
      step();
      assert (!rready_o && r_count - r_base == RD_DEPTH) else begin
         $display("Error %0t: rready_o did not drop with %0d results held, %0d R beats taken",
                  $time, RD_DEPTH, r_count - r_base);
         errors++;
      end
      repeat (10) begin
         step();
      end
      assert (!rready_o && r_count - r_base == RD_DEPTH) else begin
         $display("Error %0t: R beats accepted while the R store was full", $time);
         errors++;
      end
      pop_en = 1'b1;
      drain();
      report_test(4, "read backlog", err0);

      // One poke at every word lane of a line
      err0 = errors;
      for (int k = 0; k < N_LANES; k++) begin
         issue(1'b1, ADDR_BASE + addr_t'(k * WORD_BYTES), $urandom());
      end
      drain();
      assert (pokes_seen == pokes_issued && strb_err == 0) else begin
         $display("Error %0t: poke results %0d of %0d issued, %0d bad strobe beats",
                  $time, pokes_seen, pokes_issued, strb_err);
         errors++;
      end
      report_test(5, "poke responses and strobes", err0);

      assert (exp_q.size() == 0) else begin
         $display("%0d expected results never arrived", exp_q.size());
         errors++;
      end
      $display("Done: %0d results checked, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: files.f
src/pcis_pkg.sv
src/sync_fifo.sv
src/send_queue.sv
src/request_splitter.sv
src/response_collector.sv
src/pcis_host_top.sv
bench/axi_slave_model.sv
bench/tb_pcis_host.sv

// File: Bender.yml
package:
  name: pcis_host

sources:
  - src/pcis_pkg.sv
  - src/sync_fifo.sv
  - src/send_queue.sv
  - src/request_splitter.sv
  - src/response_collector.sv
  - src/pcis_host_top.sv
  - target: test
    files:
      - bench/axi_slave_model.sv
      - bench/tb_pcis_host.sv
